/* src/isa_pkg.sv */
package isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Upper 20 bits of the immediate
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, viewed per format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        u_fmt_t      u;
        b_fmt_t      b;
        j_fmt_t      j;
        logic [31:0] raw;
    } instr_u;

endpackage

/* src/core_pkg.sv */
package core_pkg;

    // Fetched word with the address it came from
    typedef struct packed {
        logic [31:0]     pc;
        isa_pkg::instr_u instr;
    } fetch_entry_t;

    // Change of flow from the execution core
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // Architectural trace of one executed instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] data;
    } retire_t;

endpackage

/* src/fetch_unit.sv */
module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0001_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Instruction bus
    output logic [31:0]             iad,
    input  logic [31:0]             idt,
    input  logic                    acki_n,

    // Queue side
    input  logic                    full,
    input  core_pkg::redirect_t     redirect,
    output logic                    push,
    output core_pkg::fetch_entry_t  push_entry
);

    logic [31:0] pc_q;

    // Address always comes straight from the PC register
    assign iad = pc_q;

    // Word is taken only with room in the queue and no flow change
    assign push = !acki_n && !full && !redirect.valid;

    always_comb begin
        push_entry.pc        = pc_q;
        push_entry.instr.raw = idt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect.valid) begin
            // Redirect wins over any capture this cycle
            pc_q <= redirect.target;
        end else if (push) begin
            pc_q <= pc_q + 32'd4;
        end
    end

endmodule

/* src/instr_queue.sv */
module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  core_pkg::fetch_entry_t  push_entry,
    input  logic                    pop,
    input  logic                    flush,
    output core_pkg::fetch_entry_t  head,
    output logic                    empty,
    output logic                    full
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    core_pkg::fetch_entry_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
        end
    end

endmodule

/* src/exec_core.sv */
module exec_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_pkg::fetch_entry_t  head,
    input  logic                    empty,
    output logic                    pop,
    output core_pkg::redirect_t     redirect,
    output core_pkg::retire_t       retire,
    output logic                    retire_valid
);

    isa_pkg::instr_u   ins;
    isa_pkg::alu_op_e  alu_op;
    logic [31:0]       pc;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [4:0]        rd;
    logic [31:0]       regs [32];
    logic [31:0]       rs1_val;
    logic [31:0]       rs2_val;
    logic [31:0]       imm;
    logic [31:0]       alu_b;
    logic [31:0]       alu_res;
    logic [31:0]       link;
    logic [31:0]       target;
    logic [31:0]       wb_data;
    logic              writes_rd;
    logic              we;
    logic              alt;
    logic              br_cond;
    logic              taken;

    assign ins    = head.instr;
    assign pc     = head.pc;
    assign opcode = ins.r.opcode;
    // funct3 and rd sit at the same bits in every format that has them
    assign funct3 = ins.r.funct3;
    assign rd     = ins.r.rd;

    // x0 reads as zero
    assign rs1_val = (ins.r.rs1 == 5'd0) ? 32'd0 : regs[ins.r.rs1];
    assign rs2_val = (ins.r.rs2 == 5'd0) ? 32'd0 : regs[ins.r.rs2];

    // Immediate per format
    always_comb begin
        case (opcode)
            isa_pkg::OPC_OP_IMM, isa_pkg::OPC_JALR:
                imm = {{20{ins.i.imm[11]}}, ins.i.imm};
            isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC:
                imm = {ins.u.imm, 12'd0};
            isa_pkg::OPC_BRANCH:
                imm = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5,
                       ins.b.imm_4_1, 1'b0};
            isa_pkg::OPC_JAL:
                imm = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11,
                       ins.j.imm_10_1, 1'b0};
            default:
                imm = 32'd0;
        endcase
    end

    // sub and sra are marked in funct7, the upper bits of an I immediate too
    assign alt = (ins.r.funct7 == isa_pkg::F7_ALT);

    always_comb begin
        case (funct3)
            isa_pkg::F3_ADD_SUB:
                alu_op = (opcode == isa_pkg::OPC_OP && alt) ? isa_pkg::ALU_SUB
                                                            : isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     alu_op = isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     alu_op = isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    alu_op = isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     alu_op = isa_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: alu_op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:      alu_op = isa_pkg::ALU_OR;
            default:             alu_op = isa_pkg::ALU_AND;
        endcase
    end

    assign alu_b = (opcode == isa_pkg::OPC_OP) ? rs2_val : imm;

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD:  alu_res = rs1_val + alu_b;
            isa_pkg::ALU_SUB:  alu_res = rs1_val - alu_b;
            isa_pkg::ALU_AND:  alu_res = rs1_val & alu_b;
            isa_pkg::ALU_OR:   alu_res = rs1_val | alu_b;
            isa_pkg::ALU_XOR:  alu_res = rs1_val ^ alu_b;
            isa_pkg::ALU_SLT:  alu_res = {31'd0, $signed(rs1_val) < $signed(alu_b)};
            isa_pkg::ALU_SLTU: alu_res = {31'd0, rs1_val < alu_b};
            isa_pkg::ALU_SLL:  alu_res = rs1_val << alu_b[4:0];
            isa_pkg::ALU_SRL:  alu_res = rs1_val >> alu_b[4:0];
            isa_pkg::ALU_SRA:  alu_res = $unsigned($signed(rs1_val) >>> alu_b[4:0]);
            default:           alu_res = 32'd0;
        endcase
    end

    // Branch condition, undefined funct3 never taken
    always_comb begin
        case (ins.b.funct3)
            isa_pkg::F3_BEQ:  br_cond = (rs1_val == rs2_val);
            isa_pkg::F3_BNE:  br_cond = (rs1_val != rs2_val);
            isa_pkg::F3_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            isa_pkg::F3_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            isa_pkg::F3_BLTU: br_cond = (rs1_val < rs2_val);
            isa_pkg::F3_BGEU: br_cond = (rs1_val >= rs2_val);
            default:          br_cond = 1'b0;
        endcase
    end

    assign link = pc + 32'd4;

    always_comb begin
        target    = pc + imm;
        taken     = 1'b0;
        writes_rd = 1'b1;
        wb_data   = alu_res;
        case (opcode)
            isa_pkg::OPC_OP, isa_pkg::OPC_OP_IMM: begin
                wb_data = alu_res;
            end
            isa_pkg::OPC_LUI:   wb_data = imm;
            isa_pkg::OPC_AUIPC: wb_data = pc + imm;
            isa_pkg::OPC_JAL: begin
                taken   = 1'b1;
                wb_data = link;
            end
            isa_pkg::OPC_JALR: begin
                target  = (rs1_val + imm) & ~32'd1;
                taken   = 1'b1;
                wb_data = link;
            end
            isa_pkg::OPC_BRANCH: begin
                taken     = br_cond;
                writes_rd = 1'b0;
                wb_data   = 32'd0;
            end
            default: begin
                writes_rd = 1'b0;
                wb_data   = 32'd0;
            end
        endcase
    end

    assign pop = !empty;
    assign we  = writes_rd && (rd != 5'd0);

    // Only a real change of flow flushes the front end
    assign redirect.valid  = pop && taken && (target != link);
    assign redirect.target = target;

    always_ff @(posedge clk) begin
        if (pop && we) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire.pc   <= pc;
            retire.rd   <= writes_rd ? rd : 5'd0;
            retire.we   <= we;
            retire.data <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
        end
    end

endmodule

/* src/core_top.sv */
module core_top #(
    parameter logic [31:0] RESET_PC    = 32'h0001_0000,
    parameter int          QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,

    // Instruction memory
    output logic [31:0]        iad,
    input  logic [31:0]        idt,
    input  logic               acki_n,

    // Trace of executed instructions
    output core_pkg::retire_t  retire,
    output logic               retire_valid
);

    logic                    push;
    logic                    pop;
    logic                    empty;
    logic                    full;
    core_pkg::fetch_entry_t  push_entry;
    core_pkg::fetch_entry_t  head;
    core_pkg::redirect_t     redirect;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .iad        (iad),
        .idt        (idt),
        .acki_n     (acki_n),
        .full       (full),
        .redirect   (redirect),
        .push       (push),
        .push_entry (push_entry)
    );

    // A redirect also empties the queue
    instr_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .flush      (redirect.valid),
        .head       (head),
        .empty      (empty),
        .full       (full)
    );

    exec_core exec0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .redirect     (redirect),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

endmodule

/* verif/core_checker.sv */
module core_checker (
    input logic                clk,
    input logic                rst_n,
    input logic [31:0]         iad,
    input logic                acki_n,
    input logic                full,
    input core_pkg::redirect_t redirect,
    input logic                retire_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;

    // Full queue holds the fetch address, so the word is asked for again
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
                                        (full && !redirect.valid) |=> $stable(iad))
        else begin
            assert_fails++;
            $error("fetch advanced while the queue was full");
        end

    // First edge out of reset
    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid)
        else begin
            assert_fails++;
            $error("retire_valid high right after reset");
        end

    single_redirect: assert property (@(posedge clk) disable iff (!rst_n)
                                      redirect.valid |=> !redirect.valid)
        else begin
            assert_fails++;
            $error("redirect valid on two cycles in a row");
        end

    iad_held: assert property (@(posedge clk) disable iff (!rst_n)
                               (acki_n && !redirect.valid) |=> $stable(iad))
        else begin
            assert_fails++;
            $error("iad moved without acknowledge or redirect");
        end

endmodule

bind core_top core_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .iad          (iad),
    .acki_n       (acki_n),
    .full         (full),
    .redirect     (redirect),
    .retire_valid (retire_valid)
);

/* verif/core_tb.sv */
module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC    = 32'h0001_0000;
    localparam int          PROG_WORDS  = 64;
    localparam int          NUM_RETIRE  = 300;
    localparam int          CYCLE_LIMIT = NUM_RETIRE * 8 + 100;
    localparam logic [6:0]  OPC_OP      = 7'b0110011;
    localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0]  OPC_LUI     = 7'b0110111;
    localparam logic [6:0]  OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0]  OPC_JAL     = 7'b1101111;
    localparam logic [6:0]  OPC_JALR    = 7'b1100111;
    localparam logic [6:0]  OPC_BRANCH  = 7'b1100011;
    // custom-0, not implemented by the core
    localparam logic [6:0]  OPC_CUSTOM  = 7'b0001011;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [31:0]       iad;
    logic [31:0]       idt;
    logic              acki_n;
    core_pkg::retire_t retire;
    logic              retire_valid;

    logic [31:0]       prog [PROG_WORDS];
    logic [31:0]       ref_regs [32];
    logic [31:0]       ref_pc;
    logic [31:0]       next_pc;
    core_pkg::retire_t exp_ret;
    logic [31:0]       lcg_state;
    int                retired;
    int                cycles;
    int                mismatches;
    int                other_errors;

    core_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .iad          (iad),
        .idt          (idt),
        .acki_n       (acki_n),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % 32'(n));
    endfunction

    // Past the program end the memory returns address-dependent custom-0 words
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - RESET_PC;
        if (offs < 32'(PROG_WORDS * 4)) return prog[offs[7:2]];
        return {addr[31:7] ^ addr[24:0], OPC_CUSTOM};
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        int          tgt;
        int          lo;
        int          hi;
        // x1..x14 start random, x15 holds the program base for JALR
        for (int i = 0; i < 14; i++) begin
            rnd = lcg_next();
            prog[i] = {rnd[31:20], 5'd0, 3'd0, 5'(i + 1), OPC_OP_IMM};
        end
        prog[14] = {RESET_PC[31:12], 5'd15, OPC_LUI};
        for (int i = 15; i < PROG_WORDS - 1; i++) begin
            rnd = lcg_next();
            rd  = 5'(rand_below(15));
            rs1 = 5'(rand_below(16));
            rs2 = 5'(rand_below(16));
            f3  = 3'(rand_below(8));
            // Jumps only go a few words forward
            tgt = i + 1 + rand_below(4);
            if (tgt >= PROG_WORDS) tgt = PROG_WORDS - 1;
            case (rand_below(10))
                0, 1, 2: begin
                    imm12 = {1'b0, rnd[13] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2};
                    prog[i] = {imm12, rs1, f3, rd, OPC_OP};
                end
                3, 4: begin
                    imm12 = rnd[31:20];
                    // Shift amount in 5 bits, bit 10 selects srai
                    if (f3 == 3'd1) imm12[11:5] = 7'd0;
                    if (f3 == 3'd5) imm12[11:5] = {1'b0, rnd[13], 5'd0};
                    prog[i] = {imm12, rs1, f3, rd, OPC_OP_IMM};
                end
                5: prog[i] = {rnd[31:12], rd, rnd[11] ? OPC_LUI : OPC_AUIPC};
                6: begin
                    joff = 21'((tgt - i) * 4);
                    prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
                end
                7: prog[i] = {12'(tgt * 4 + int'(rnd[13])), 5'd15, 3'd0, rd, OPC_JALR};
                8: begin
                    lo = (i - 8 < 15) ? 15 : i - 8;
                    hi = (i + 8 >= PROG_WORDS) ? PROG_WORDS - 1 : i + 8;
                    tgt = lo + rand_below(hi - lo + 1);
                    if (tgt == i) tgt = i + 1;
                    boff = 13'((tgt - i) * 4);
                    // funct3 2 and 3 are not branches, move them to 6 and 7
                    if (f3[1]) f3[2] = 1'b1;
                    prog[i] = {boff[12], boff[10:5], rs2, rs1, f3,
                               boff[4:1], boff[11], OPC_BRANCH};
                end
                default: prog[i] = {rnd[31:7], OPC_CUSTOM};
            endcase
        end
        // jal x0, 0 spins at the end
        prog[PROG_WORDS - 1] = {25'd0, OPC_JAL};
    endtask

    // ISA model of one instruction on ref_regs
    function automatic void ref_step(input logic [31:0] pc, input logic [31:0] w,
                                     output core_pkg::retire_t exp_r,
                                     output logic [31:0] npc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] imm_i;
        logic [31:0] val;
        logic        alt;
        logic        writes;
        logic        taken;
        imm_i  = {{20{w[31]}}, w[31:20]};
        a      = ref_regs[w[19:15]];
        c      = ref_regs[w[24:20]];
        b      = (w[6:0] == OPC_OP) ? c : imm_i;
        alt    = w[30] && (w[14:12] == 3'd5 || w[6:0] == OPC_OP);
        npc    = pc + 32'd4;
        writes = 1'b1;
        val    = 32'd0;
        taken  = 1'b0;
        case (w[6:0])
            OPC_OP, OPC_OP_IMM: begin
                case (w[14:12])
                    3'd0:    val = alt ? a - b : a + b;
                    3'd1:    val = a << b[4:0];
                    3'd2:    val = {31'd0, $signed(a) < $signed(b)};
                    3'd3:    val = {31'd0, a < b};
                    3'd4:    val = a ^ b;
                    3'd5:    val = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6:    val = a | b;
                    default: val = a & b;
                endcase
            end
            OPC_LUI:   val = {w[31:12], 12'd0};
            OPC_AUIPC: val = pc + {w[31:12], 12'd0};
            OPC_JAL: begin
                val = pc + 32'd4;
                npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                val = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                case (w[14:12])
                    3'd0:    taken = (a == c);
                    3'd1:    taken = (a != c);
                    3'd4:    taken = ($signed(a) < $signed(c));
                    3'd5:    taken = ($signed(a) >= $signed(c));
                    3'd6:    taken = (a < c);
                    3'd7:    taken = (a >= c);
                    default: taken = 1'b0;
                endcase
                if (taken) npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            default: writes = 1'b0;
        endcase
        if (writes && w[11:7] != 5'd0) ref_regs[w[11:7]] = val;
        exp_r.pc   = pc;
        exp_r.rd   = writes ? w[11:7] : 5'd0;
        exp_r.we   = writes && (w[11:7] != 5'd0);
        exp_r.data = val;
    endfunction

    // Memory answers on the falling edge, acknowledge low about 70 percent
    always @(negedge clk) begin
        idt    <= mem_word(iad);
        acki_n <= (rand_below(10) >= 7);
    end

    // Retire record is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && retire_valid && retired < NUM_RETIRE) begin
            ref_step(ref_pc, mem_word(ref_pc), exp_ret, next_pc);
            if (retire.pc !== exp_ret.pc) begin
                mismatches++;
                $display("mismatch retire.pc expected %h actual %h", exp_ret.pc, retire.pc);
            end
            if (retire.rd !== exp_ret.rd) begin
                mismatches++;
                $display("mismatch retire.rd expected %h actual %h", exp_ret.rd, retire.rd);
            end
            if (retire.we !== exp_ret.we) begin
                mismatches++;
                $display("mismatch retire.we expected %h actual %h", exp_ret.we, retire.we);
            end
            if (retire.data !== exp_ret.data) begin
                mismatches++;
                $display("mismatch retire.data expected %h actual %h",
                         exp_ret.data, retire.data);
            end
            ref_pc = next_pc;
            retired++;
        end
    end

    initial begin
        rst_n        = 1'b0;
        acki_n       = 1'b1;
        idt          = 32'd0;
        lcg_state    = 32'd7995;
        ref_pc       = RESET_PC;
        retired      = 0;
        cycles       = 0;
        mismatches   = 0;
        other_errors = 0;
        for (int r = 0; r < 32; r++) ref_regs[r] = 32'd0;
        build_program();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (retired < NUM_RETIRE && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < NUM_RETIRE) begin
            other_errors++;
            $display("timeout: retirements stopped at %0d of %0d", retired, NUM_RETIRE);
        end
        $display("retired %0d, mismatches %0d, assertion failures %0d, other errors %0d",
                 retired, mismatches, dut0.chk0.assert_fails, other_errors);
        if (mismatches == 0 && other_errors == 0 && dut0.chk0.assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* files.f */
src/isa_pkg.sv
src/core_pkg.sv
src/fetch_unit.sv
src/instr_queue.sv
src/exec_core.sv
src/core_top.sv
verif/core_checker.sv
verif/core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module core_tb -f files.f --Mdir obj_dir -o core_sim &&
./obj_dir/core_sim 2>&1 | tee sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" && exit 0 || { echo "simulation failed"; exit 1; }
